//--- Makefile
TOP := quad_bram_ctrl_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing -f flist.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- dv/pfb_fetch_model.sv
`timescale 1ns/1ps

module pfb_fetch_model (
    input  logic clk,
    input  logic rst,
    input  int   max_delay,
    input  logic job_fetch_request,
    output logic job_fetch_ack,
    output logic job_fetch_complete
);

    int ack_delay;
    int cmpl_delay;

    // Responder for the prefetch buffer fetch handshake
    // Outputs change on the falling edge only
    initial begin
        job_fetch_ack      = 1'b0;
        job_fetch_complete = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst && job_fetch_request) begin
                // Both delays drawn per fetch within the job row bound
                ack_delay  = int'($urandom % (max_delay + 1));
                cmpl_delay = int'($urandom % (max_delay + 1));
                repeat (ack_delay) @(negedge clk);
                job_fetch_ack = 1'b1;
                @(negedge clk);
                job_fetch_ack = 1'b0;
                // Row transfer time
                repeat (cmpl_delay) @(negedge clk);
                job_fetch_complete = 1'b1;
                @(negedge clk);
                job_fetch_complete = 1'b0;
            end
        end
    end

endmodule

//--- dv/quad_bram_ctrl_tb.sv
`timescale 1ns/1ps

`include "quad_bram_ctrl_defines.svh"

module quad_bram_ctrl_tb
    import ctrl_types_pkg::*;
    import ctrl_state_pkg::*;
();

    localparam int NUM_JOBS = 5;
    localparam int CLK_HALF = 10;

    ////////////////////////////////////////////////////////////
    // Job table
    ////////////////////////////////////////////////////////////

    // cols and rows are last indices as the host writes them
    int job_cols      [NUM_JOBS] = '{3, 7, 2, 15, 5};
    int job_rows      [NUM_JOBS] = '{3, 5, 4, 3, 8};
    int job_fetch_max [NUM_JOBS] = '{0, 4, 9, 2, 6};
    int job_ack_max   [NUM_JOBS] = '{0, 3, 6, 1, 10};
    // Expected reads per output row as (cols + 1) * 5
    int job_len       [NUM_JOBS] = '{20, 40, 15, 80, 30};

    logic        clk = 1'b0;
    logic        rst;
    coord_t      num_input_cols;
    coord_t      num_input_rows;
    logic        job_start;
    logic        job_accept;
    logic        job_fetch_request;
    logic        job_fetch_ack;
    logic        job_fetch_complete;
    logic        job_complete;
    logic        job_complete_ack;
    ctrl_state_e state;
    coord_t      input_row;
    coord_t      input_col;
    logic        pfb_rden;
    logic        pix_seq_bram_rden;
    seq_addr_t   pix_seq_bram_rdaddr;
    ce_vec_t     ce_execute;
    int          fetch_delay_max = 0;

    // Running totals snapshotted per job
    int accept_cnt = 0;
    int fetch_cnt  = 0;
    int rden_cnt   = 0;
    int strobe_cnt = 0;
    int burst_cnt  = 0;
    int top_cnt    = 0;
    int mon_errors = 0;
    int chk_errors = 0;
    int pass_cnt   = 0;
    int fail_cnt   = 0;

    // Monitor tracking
    int                 cur_cols = 0;
    int                 cur_len  = 0;
    int                 exp_col  = 0;
    int                 exp_row  = 0;
    int                 burst_idx = 0;
    int                 tail_cnt  = 0;
    int                 ce_idx;
    logic               fetch_busy = 1'b0;
    logic               cur_strobe;
    logic [`NUM_CE+1:0] strobe_hist = '0;

    always #(CLK_HALF) clk = ~clk;

    quad_bram_ctrl uut (
        .clk                 (clk),
        .rst                 (rst),
        .num_input_cols      (num_input_cols),
        .num_input_rows      (num_input_rows),
        .job_start           (job_start),
        .job_accept          (job_accept),
        .job_fetch_request   (job_fetch_request),
        .job_fetch_ack       (job_fetch_ack),
        .job_fetch_complete  (job_fetch_complete),
        .job_complete        (job_complete),
        .job_complete_ack    (job_complete_ack),
        .state               (state),
        .input_row           (input_row),
        .input_col           (input_col),
        .pfb_rden            (pfb_rden),
        .pix_seq_bram_rden   (pix_seq_bram_rden),
        .pix_seq_bram_rdaddr (pix_seq_bram_rdaddr),
        .ce_execute          (ce_execute)
    );

    pfb_fetch_model fetcher (
        .clk                (clk),
        .rst                (rst),
        .max_delay          (fetch_delay_max),
        .job_fetch_request  (job_fetch_request),
        .job_fetch_ack      (job_fetch_ack),
        .job_fetch_complete (job_fetch_complete)
    );

    task automatic print_error(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
    endtask

    task automatic compare_count(input string what, input int got, input int want);
        if (got != want) begin
            print_error($sformatf("%s count %0d, expected %0d", what, got, want));
            chk_errors++;
        end
    endtask

    // Budget from job sizes and delay bounds, plus reset margin
    function automatic int watchdog_cycles();
        int total;
        int k;
        total = 100;
        for (k = 0; k < NUM_JOBS; k++) begin
            total += (job_rows[k] + 1) * (job_cols[k] + 1) * 5 * 4;
            total += (job_rows[k] + 1) * 2 * job_fetch_max[k] + job_ack_max[k];
        end
        return total;
    endfunction

    ////////////////////////////////////////////////////////////
    // Monitor sampled on the rising edge
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (rst) begin
            strobe_hist = '0;
            fetch_busy  = 1'b0;
            burst_idx   = 0;
            tail_cnt    = 0;
        end else begin
            // New job restarts the input position
            if (job_accept) begin
                accept_cnt++;
                exp_col = 0;
                exp_row = 0;
            end
            if (job_fetch_request && fetch_busy) begin
                print_error("fetch request raised while a fetch is in progress");
                mon_errors++;
            end
            if (job_fetch_request && job_fetch_ack) begin
                fetch_cnt++;
                fetch_busy = 1'b1;
            end
            if (job_fetch_complete) begin
                fetch_busy = 1'b0;
            end
            // Buffer reads walk columns then rows
            if (pfb_rden) begin
                rden_cnt++;
                if (int'(input_col) != exp_col || int'(input_row) != exp_row) begin
                    print_error($sformatf("input position %0d/%0d, expected %0d/%0d",
                        input_row, input_col, exp_row, exp_col));
                    mon_errors++;
                end
                if (exp_col == cur_cols) begin
                    exp_col = 0;
                    exp_row++;
                end else begin
                    exp_col++;
                end
            end
            // First cur_len enable cycles of a burst are strobes and the rest is the tail
            cur_strobe = 1'b0;
            if (pix_seq_bram_rden) begin
                if (burst_idx < cur_len) begin
                    cur_strobe = 1'b1;
                    strobe_cnt++;
                    if (int'(pix_seq_bram_rdaddr) != burst_idx) begin
                        print_error($sformatf("sequence address %0d, expected %0d",
                            pix_seq_bram_rdaddr, burst_idx));
                        mon_errors++;
                    end
                    burst_idx++;
                end else begin
                    tail_cnt++;
                end
            end else if (burst_idx != 0) begin
                burst_cnt++;
                if (burst_idx != cur_len || tail_cnt != `SEQ_RDEN_HOLD) begin
                    print_error($sformatf("read burst of %0d strobes and %0d tail cycles",
                        burst_idx, tail_cnt));
                    mon_errors++;
                end
                burst_idx = 0;
                tail_cnt  = 0;
            end
            // Engine i fires 3 + i cycles after its strobe
            for (ce_idx = 0; ce_idx < `NUM_CE; ce_idx++) begin
                if (ce_execute[ce_idx] != strobe_hist[ce_idx+2]) begin
                    print_error($sformatf("ce_execute[%0d] is %0b, expected %0b",
                        ce_idx, ce_execute[ce_idx], strobe_hist[ce_idx+2]));
                    mon_errors++;
                end
            end
            if (ce_execute[`NUM_CE-1]) begin
                top_cnt++;
            end
            strobe_hist = {strobe_hist[`NUM_CE:0], cur_strobe};
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus driven on the falling edge
    ////////////////////////////////////////////////////////////

    task automatic check_idle_outputs();
        if (job_accept || job_fetch_request || job_complete || pfb_rden ||
            pix_seq_bram_rden || ce_execute != '0) begin
            print_error("control output high while idle");
            chk_errors++;
        end
        if (state != ST_IDLE) begin
            print_error($sformatf("state %0b while idle", state));
            chk_errors++;
        end
    endtask

    task automatic run_job(input int j);
        int ack_wait;
        int base_accept;
        int base_fetch;
        int base_rden;
        int base_strobe;
        int base_burst;
        int base_top;
        int errs_before;
        cur_cols        = job_cols[j];
        cur_len         = job_len[j];
        fetch_delay_max = job_fetch_max[j];
        base_accept     = accept_cnt;
        base_fetch      = fetch_cnt;
        base_rden       = rden_cnt;
        base_strobe     = strobe_cnt;
        base_burst      = burst_cnt;
        base_top        = top_cnt;
        errs_before     = chk_errors + mon_errors;
        @(negedge clk);
        num_input_cols = coord_t'(job_cols[j]);
        num_input_rows = coord_t'(job_rows[j]);
        job_start      = 1'b1;
        @(negedge clk);
        job_start = 1'b0;
        if (!job_accept) begin
            print_error("job_accept missing one cycle after job_start");
            chk_errors++;
        end
        // Geometry is latched so the host inputs may change
        num_input_cols = coord_t'($urandom);
        num_input_rows = coord_t'($urandom);
        while (!job_complete) begin
            @(negedge clk);
        end
        if (state != ST_JOB_DONE) begin
            print_error("job_complete high outside the done state");
            chk_errors++;
        end
        // Slow host must see complete held
        ack_wait = int'($urandom % (job_ack_max[j] + 1));
        repeat (ack_wait) begin
            @(negedge clk);
            if (!job_complete) begin
                print_error("job_complete dropped before acknowledge");
                chk_errors++;
            end
        end
        job_complete_ack = 1'b1;
        @(negedge clk);
        job_complete_ack = 1'b0;
        if (job_complete || state != ST_IDLE) begin
            print_error("job not released one cycle after acknowledge");
            chk_errors++;
        end
        compare_count("job_accept", accept_cnt - base_accept, 1);
        compare_count("fetch", fetch_cnt - base_fetch, job_rows[j] + 1);
        compare_count("pfb_rden", rden_cnt - base_rden, (job_rows[j] + 1) * (job_cols[j] + 1));
        compare_count("read strobe", strobe_cnt - base_strobe, (job_rows[j] + 1) * job_len[j]);
        compare_count("row burst", burst_cnt - base_burst, job_rows[j] + 1);
        compare_count("top-stage execute", top_cnt - base_top, (job_rows[j] + 1) * job_len[j]);
        if (chk_errors + mon_errors == errs_before) begin
            pass_cnt++;
            $display("job %0d (cols %0d, rows %0d): ok", j, job_cols[j], job_rows[j]);
        end else begin
            fail_cnt++;
            $display("job %0d (cols %0d, rows %0d): %0d errors", j, job_cols[j], job_rows[j],
                chk_errors + mon_errors - errs_before);
        end
    endtask

    initial begin
        void'($urandom(32'h95973c01));
        rst              = 1'b1;
        num_input_cols   = '0;
        num_input_rows   = '0;
        job_start        = 1'b0;
        job_complete_ack = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // Quiet outputs before any job
        check_idle_outputs();
        repeat (2) begin
            @(negedge clk);
            check_idle_outputs();
        end
        if (chk_errors == 0) begin
            pass_cnt++;
            $display("reset check: ok");
        end else begin
            fail_cnt++;
            $display("reset check: %0d errors", chk_errors);
        end
        for (int j = 0; j < NUM_JOBS; j++) begin
            run_job(j);
        end
        $display("Summary: %0d tests ok, %0d with errors", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && chk_errors + mon_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Hang guard
    initial begin
        int limit;
        limit = watchdog_cycles();
        #(limit * 2 * CLK_HALF);
        $display("Watchdog: run did not finish within %0d cycles", limit);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

//--- flist.f
+incdir+include
verilog/ctrl_types_pkg.sv
verilog/ctrl_state_pkg.sv
verilog/job_config_regs.sv
verilog/job_sequencer.sv
verilog/prefetch_reader.sv
verilog/pix_seq_reader.sv
verilog/quad_bram_ctrl.sv
dv/pfb_fetch_model.sv
dv/quad_bram_ctrl_tb.sv

//--- include/quad_bram_ctrl_defines.svh
`ifndef QUAD_BRAM_CTRL_DEFINES_SVH
`define QUAD_BRAM_CTRL_DEFINES_SVH

// Words per BRAM
`define BRAM_DEPTH          1024
// Row and column counters span half a BRAM
`define COORD_W             9
// Compute engines along the execute chain
`define NUM_CE              8

// Sequence reads issued for every output pixel
`define SEQ_READS_PER_PIX   5
`define SEQ_ADDR_W          12

// Read strobe to first execute stage without the chain input register
`define CE_START_DELAY      2
// Extra enable cycles for the sequence BRAM read latency
`define SEQ_RDEN_HOLD       3
// Input rows loaded before the first output row
`define PRIME_ROWS          4

`endif

//--- verilog/ctrl_state_pkg.sv
package ctrl_state_pkg;

    // Sequencer states, one-hot
    typedef enum logic [4:0] {
        ST_IDLE          = 5'b00001,
        ST_PRIME_BUFFER  = 5'b00010,
        ST_WAIT_PFB_LOAD = 5'b00100,
        ST_ACTIVE        = 5'b01000,
        ST_JOB_DONE      = 5'b10000
    } ctrl_state_e;

endpackage

//--- verilog/ctrl_types_pkg.sv
package ctrl_types_pkg;

    `include "quad_bram_ctrl_defines.svh"

    ////////////////////////////////////////////////////////////
    // Datapath vector types
    ////////////////////////////////////////////////////////////

    // Input or output row / column index
    typedef logic [`COORD_W-1:0] coord_t;

    // Sequence BRAM address
    // Also the per-row sequence length
    typedef logic [`SEQ_ADDR_W-1:0] seq_addr_t;

    // Prefetch buffer words still to read
    // One bit wider than a column index to hold cols + 1
    typedef logic [`COORD_W:0] pfb_count_t;

    // One execute bit per compute engine
    typedef logic [`NUM_CE-1:0] ce_vec_t;

endpackage

//--- verilog/job_config_regs.sv
`timescale 1ns/1ps

`include "quad_bram_ctrl_defines.svh"

module job_config_regs
    import ctrl_types_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      cfg_load,
    input  coord_t    num_input_cols,
    input  coord_t    num_input_rows,
    output coord_t    cfg_cols,
    output coord_t    cfg_rows,
    output seq_addr_t seq_row_len
);

    // Geometry is captured once on accept
    // Host may change the inputs for the rest of the job
    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_cols    <= '0;
            cfg_rows    <= '0;
            seq_row_len <= '0;
        end else if (cfg_load) begin
            cfg_cols <= num_input_cols;
            cfg_rows <= num_input_rows;
            // Reads per output row
            // cols is the last index so the row holds cols + 1 pixels
            seq_row_len <= seq_addr_t'((num_input_cols + 1) * `SEQ_READS_PER_PIX);
        end
    end

endmodule

//--- verilog/job_sequencer.sv
`timescale 1ns/1ps

`include "quad_bram_ctrl_defines.svh"

module job_sequencer
    import ctrl_types_pkg::*;
    import ctrl_state_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        job_start,
    output logic        job_accept,
    output logic        job_fetch_request,
    input  logic        job_fetch_ack,
    input  logic        job_fetch_complete,
    output logic        job_complete,
    input  logic        job_complete_ack,
    input  logic        fetch_in_progress,
    input  pfb_count_t  pfb_count,
    input  coord_t      input_row,
    input  coord_t      output_row,
    input  coord_t      cfg_rows,
    input  logic        row_drained,
    output logic        cfg_load,
    output logic        fetch_done,
    output logic        prime_en,
    output logic        active_en,
    output logic        row_start,
    output ctrl_state_e state
);

    ctrl_state_e return_state;
    logic        fetch_acked;
    // output_row keeps counting across jobs
    coord_t      row_base;

    ////////////////////////////////////////////////////////////
    // Decodes toward the datapath
    ////////////////////////////////////////////////////////////

    // Geometry latches on the accepting edge
    assign cfg_load   = (state == ST_IDLE) && job_start;
    // Only a complete that follows an ack counts
    assign fetch_done = job_fetch_complete && fetch_in_progress;

    // Enables also cover a fetch wait of their own phase
    // so buffer positions hold while a row loads
    assign prime_en  = (state == ST_PRIME_BUFFER) ||
                       ((state == ST_WAIT_PFB_LOAD) && (return_state == ST_PRIME_BUFFER));
    assign active_en = (state == ST_ACTIVE) ||
                       ((state == ST_WAIT_PFB_LOAD) && (return_state == ST_ACTIVE));

    ////////////////////////////////////////////////////////////
    // Controller FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state             <= ST_IDLE;
            return_state      <= ST_IDLE;
            job_accept        <= 1'b0;
            job_fetch_request <= 1'b0;
            fetch_acked       <= 1'b0;
            job_complete      <= 1'b0;
            row_start         <= 1'b0;
            row_base          <= '0;
        end else begin
            // Single-cycle strobes
            job_accept <= 1'b0;
            row_start  <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (job_start) begin
                        job_accept <= 1'b1;
                        row_base   <= output_row;
                        state      <= ST_PRIME_BUFFER;
                    end
                end
                ST_PRIME_BUFFER: begin
                    // Decide only once the loaded row is fully read
                    if (pfb_count == '0) begin
                        if (input_row == coord_t'(`PRIME_ROWS)) begin
                            row_start <= 1'b1;
                            state     <= ST_ACTIVE;
                        end else begin
                            return_state <= ST_PRIME_BUFFER;
                            state        <= ST_WAIT_PFB_LOAD;
                        end
                    end
                end
                ST_WAIT_PFB_LOAD: begin
                    // Request held until ack then dropped
                    // Never re-raised within the same fetch
                    if (job_fetch_ack) begin
                        job_fetch_request <= 1'b0;
                        fetch_acked       <= 1'b1;
                    end else if (!fetch_acked && !fetch_in_progress) begin
                        job_fetch_request <= 1'b1;
                    end
                    if (fetch_done) begin
                        fetch_acked <= 1'b0;
                        state       <= return_state;
                        // Row start deferred until the new row has landed
                        if (return_state == ST_ACTIVE) begin
                            row_start <= 1'b1;
                        end
                    end
                end
                ST_ACTIVE: begin
                    if (row_drained) begin
                        if (coord_t'(output_row - row_base) == coord_t'(cfg_rows + 1)) begin
                            job_complete <= 1'b1;
                            state        <= ST_JOB_DONE;
                        end else if (input_row != coord_t'(cfg_rows + 1)) begin
                            // Input rows left to bring in
                            return_state <= ST_ACTIVE;
                            state        <= ST_WAIT_PFB_LOAD;
                        end else begin
                            row_start <= 1'b1;
                        end
                    end
                end
                ST_JOB_DONE: begin
                    // Complete held until the host acks
                    if (job_complete_ack) begin
                        job_complete <= 1'b0;
                        state        <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

//--- verilog/pix_seq_reader.sv
`timescale 1ns/1ps

`include "quad_bram_ctrl_defines.svh"

module pix_seq_reader
    import ctrl_types_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      row_start,
    input  seq_addr_t seq_row_len,
    input  coord_t    cfg_cols,
    output logic      pix_seq_bram_rden,
    output seq_addr_t pix_seq_bram_rdaddr,
    output ce_vec_t   ce_execute,
    output coord_t    output_row,
    output logic      row_drained
);

    seq_addr_t                     rd_left;
    logic                          rd_strobe;
    logic [2:0]                    cyc_cnt;
    logic                          pix_done;
    coord_t                        output_col;
    logic [`CE_START_DELAY-1:0]    start_sr;
    logic [`SEQ_RDEN_HOLD-1:0]     hold_sr;

    // Internal strobe while reads of the row remain
    assign rd_strobe = (rd_left != '0);
    assign pix_done  = rd_strobe && (cyc_cnt == 3'(`SEQ_READS_PER_PIX - 1));

    // Enable tail covers BRAM read latency
    assign pix_seq_bram_rden = rd_strobe || (|hold_sr);

    // Nothing pending from issue down to the last engine
    assign row_drained = !row_start && !rd_strobe && (start_sr == '0) && (ce_execute == '0);

    ////////////////////////////////////////////////////////////
    // Read issue
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_left             <= '0;
            pix_seq_bram_rdaddr <= '0;
        end else begin
            if (row_start) begin
                rd_left <= seq_row_len;
            end else if (rd_strobe) begin
                rd_left <= rd_left - seq_addr_t'(1);
            end
            // Address wraps at the end of every row
            if (rd_strobe) begin
                if (pix_seq_bram_rdaddr == seq_row_len - seq_addr_t'(1)) begin
                    pix_seq_bram_rdaddr <= '0;
                end else begin
                    pix_seq_bram_rdaddr <= pix_seq_bram_rdaddr + seq_addr_t'(1);
                end
            end
        end
    end

    // Cycle counter then output column then output row
    always_ff @(posedge clk) begin
        if (rst) begin
            cyc_cnt    <= '0;
            output_col <= '0;
            output_row <= '0;
        end else begin
            if (pix_done) begin
                cyc_cnt <= '0;
            end else if (rd_strobe) begin
                cyc_cnt <= cyc_cnt + 3'd1;
            end
            if (pix_done) begin
                if (output_col == cfg_cols) begin
                    output_col <= '0;
                    output_row <= output_row + coord_t'(1);
                end else begin
                    output_col <= output_col + coord_t'(1);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Enable tail and execute chain
    ////////////////////////////////////////////////////////////

    // Strobe reaches ce_execute[0] three cycles later
    always_ff @(posedge clk) begin
        if (rst) begin
            hold_sr    <= '0;
            start_sr   <= '0;
            ce_execute <= '0;
        end else begin
            hold_sr    <= {hold_sr[`SEQ_RDEN_HOLD-2:0], rd_strobe};
            start_sr   <= {start_sr[`CE_START_DELAY-2:0], rd_strobe};
            // One engine further per cycle
            ce_execute <= {ce_execute[`NUM_CE-2:0], start_sr[`CE_START_DELAY-1]};
        end
    end

endmodule

//--- verilog/prefetch_reader.sv
`timescale 1ns/1ps

module prefetch_reader
    import ctrl_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       job_fetch_ack,
    input  logic       job_fetch_complete,
    input  logic       fetch_done,
    output logic       fetch_in_progress,
    input  logic       prime_en,
    input  logic       active_en,
    input  coord_t     cfg_cols,
    output pfb_count_t pfb_count,
    output logic       pfb_rden,
    output coord_t     input_row,
    output coord_t     input_col
);

    logic rd_en;

    // Any job phase that drains the buffer
    assign rd_en    = prime_en || active_en;
    // One word per cycle while data remains
    assign pfb_rden = rd_en && (pfb_count != '0);

    ////////////////////////////////////////////////////////////
    // Fetch tracking
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_in_progress <= 1'b0;
        end else begin
            if (job_fetch_ack) begin
                fetch_in_progress <= 1'b1;
            end
            // Complete wins
            if (job_fetch_complete) begin
                fetch_in_progress <= 1'b0;
            end
        end
    end

    // Buffer holds one input row of cols + 1 words
    always_ff @(posedge clk) begin
        if (rst) begin
            pfb_count <= '0;
        end else if (fetch_done) begin
            pfb_count <= pfb_count_t'(cfg_cols) + pfb_count_t'(1);
        end else if (pfb_rden) begin
            pfb_count <= pfb_count - pfb_count_t'(1);
        end else if (!rd_en) begin
            pfb_count <= '0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Input position
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            input_row <= '0;
            input_col <= '0;
        end else if (!rd_en) begin
            // Outside a job both positions rest at zero
            input_row <= '0;
            input_col <= '0;
        end else if (pfb_rden) begin
            if (input_col == cfg_cols) begin
                input_col <= '0;
                input_row <= input_row + coord_t'(1);
            end else begin
                input_col <= input_col + coord_t'(1);
            end
        end
    end

endmodule

//--- verilog/quad_bram_ctrl.sv
`timescale 1ns/1ps

module quad_bram_ctrl
    import ctrl_types_pkg::*;
    import ctrl_state_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  coord_t      num_input_cols,
    input  coord_t      num_input_rows,
    input  logic        job_start,
    output logic        job_accept,
    output logic        job_fetch_request,
    input  logic        job_fetch_ack,
    input  logic        job_fetch_complete,
    output logic        job_complete,
    input  logic        job_complete_ack,
    output ctrl_state_e state,
    output coord_t      input_row,
    output coord_t      input_col,
    output logic        pfb_rden,
    output logic        pix_seq_bram_rden,
    output seq_addr_t   pix_seq_bram_rdaddr,
    output ce_vec_t     ce_execute
);

    // Job geometry
    logic       cfg_load;
    coord_t     cfg_cols;
    coord_t     cfg_rows;
    seq_addr_t  seq_row_len;

    // Sequencer to buffer side
    logic       fetch_in_progress;
    logic       fetch_done;
    logic       prime_en;
    logic       active_en;
    pfb_count_t pfb_count;

    // Sequencer to pixel side
    logic       row_start;
    logic       row_drained;
    coord_t     output_row;

    job_config_regs i0_job_config_regs (
        .clk            (clk),
        .rst            (rst),
        .cfg_load       (cfg_load),
        .num_input_cols (num_input_cols),
        .num_input_rows (num_input_rows),
        .cfg_cols       (cfg_cols),
        .cfg_rows       (cfg_rows),
        .seq_row_len    (seq_row_len)
    );

    job_sequencer i0_job_sequencer (
        .clk                (clk),
        .rst                (rst),
        .job_start          (job_start),
        .job_accept         (job_accept),
        .job_fetch_request  (job_fetch_request),
        .job_fetch_ack      (job_fetch_ack),
        .job_fetch_complete (job_fetch_complete),
        .job_complete       (job_complete),
        .job_complete_ack   (job_complete_ack),
        .fetch_in_progress  (fetch_in_progress),
        .pfb_count          (pfb_count),
        .input_row          (input_row),
        .output_row         (output_row),
        .cfg_rows           (cfg_rows),
        .row_drained        (row_drained),
        .cfg_load           (cfg_load),
        .fetch_done         (fetch_done),
        .prime_en           (prime_en),
        .active_en          (active_en),
        .row_start          (row_start),
        .state              (state)
    );

    prefetch_reader i0_prefetch_reader (
        .clk                (clk),
        .rst                (rst),
        .job_fetch_ack      (job_fetch_ack),
        .job_fetch_complete (job_fetch_complete),
        .fetch_done         (fetch_done),
        .fetch_in_progress  (fetch_in_progress),
        .prime_en           (prime_en),
        .active_en          (active_en),
        .cfg_cols           (cfg_cols),
        .pfb_count          (pfb_count),
        .pfb_rden           (pfb_rden),
        .input_row          (input_row),
        .input_col          (input_col)
    );

    pix_seq_reader i0_pix_seq_reader (
        .clk                 (clk),
        .rst                 (rst),
        .row_start           (row_start),
        .seq_row_len         (seq_row_len),
        .cfg_cols            (cfg_cols),
        .pix_seq_bram_rden   (pix_seq_bram_rden),
        .pix_seq_bram_rdaddr (pix_seq_bram_rdaddr),
        .ce_execute          (ce_execute),
        .output_row          (output_row),
        .row_drained         (row_drained)
    );

endmodule
